// ==== rtl/input_consts.svh ====
`ifndef INPUT_CONSTS_SVH
`define INPUT_CONSTS_SVH

// word handed to data memory
`define ISA_WIDTH 32

`define SWITCH_CNT 16 // toggle switches on the board

// digits that fit on the seven-segment tubes
`define MAX_DIGITS 10

`endif

// ==== rtl/keypad_pkg.sv ====
package keypad_pkg;

    typedef logic [7:0] key_code_t; // {row_val, col_val}, active low lines
    typedef logic [3:0] digit_t;    // 0 to 9 only

    localparam key_code_t KC_IDLE      = 8'h00; // no press this cycle
    localparam key_code_t KC_ZERO      = 8'b0111_1101;
    localparam key_code_t KC_ONE       = 8'b1110_1110;
    localparam key_code_t KC_TWO       = 8'b1110_1101;
    localparam key_code_t KC_THREE     = 8'b1110_1011;
    localparam key_code_t KC_FOUR      = 8'b1101_1110;
    localparam key_code_t KC_FIVE      = 8'b1101_1101;
    localparam key_code_t KC_SIX       = 8'b1101_1011;
    localparam key_code_t KC_SEVEN     = 8'b1011_1110;
    localparam key_code_t KC_EIGHT     = 8'b1011_1101;
    localparam key_code_t KC_NINE      = 8'b1011_1011;
    localparam key_code_t KC_BACKSPACE = 8'b0111_1110; // "*" key
    localparam key_code_t KC_ENTER     = 8'b0111_1011; // "#" key
    localparam key_code_t KC_PAUSE     = 8'b1110_0111; // "A", stop or resume the cpu
    localparam key_code_t KC_TOGGLE    = 8'b1101_0111; // "B", switches vs keypad
    localparam key_code_t KC_C         = 8'b1011_0111; // unused
    localparam key_code_t KC_D         = 8'b0111_0111; // unused

    // what a press means to the controller
    typedef enum logic [2:0] {
        KEY_NONE,
        KEY_DIGIT,
        KEY_BACKSPACE,
        KEY_ENTER,
        KEY_PAUSE,
        KEY_TOGGLE
    } key_kind_t;

endpackage

// ==== rtl/input_ctrl_pkg.sv ====
package input_ctrl_pkg;

    typedef enum logic [1:0] {
        ST_BLOCK,  // waiting for data memory to ask for input
        ST_SWITCH, // value comes from the toggle switches
        ST_KEYPAD, // value is being typed
        ST_HALT    // cpu paused by the user
    } input_state_t;

    typedef enum logic [1:0] {
        ACC_HOLD,
        ACC_CLEAR,
        ACC_PUSH, // value * 10 + digit
        ACC_POP   // value / 10
    } accum_op_t;

    typedef enum logic [1:0] {
        CNT_HOLD,
        CNT_CLEAR,
        CNT_INC,
        CNT_DEC
    } count_op_t;

endpackage

// ==== rtl/key_decode.sv ====
`timescale 1ns/1ns

module key_decode (
    input  keypad_pkg::key_code_t key_coord,
    output keypad_pkg::key_kind_t key_kind,
    output keypad_pkg::digit_t    key_digit
);
    import keypad_pkg::*;

    // digit value, zero for anything that is not a digit key
    always_comb begin
        case (key_coord)
            KC_ZERO:  key_digit = 4'd0;
            KC_ONE:   key_digit = 4'd1;
            KC_TWO:   key_digit = 4'd2;
            KC_THREE: key_digit = 4'd3;
            KC_FOUR:  key_digit = 4'd4;
            KC_FIVE:  key_digit = 4'd5;
            KC_SIX:   key_digit = 4'd6;
            KC_SEVEN: key_digit = 4'd7;
            KC_EIGHT: key_digit = 4'd8;
            KC_NINE:  key_digit = 4'd9;
            default:  key_digit = 4'd0;
        endcase
    end

    always_comb begin
        case (key_coord)
            KC_ZERO,
            KC_ONE,
            KC_TWO,
            KC_THREE,
            KC_FOUR,
            KC_FIVE,
            KC_SIX,
            KC_SEVEN,
            KC_EIGHT,
            KC_NINE:      key_kind = KEY_DIGIT;
            KC_BACKSPACE: key_kind = KEY_BACKSPACE;
            KC_ENTER:     key_kind = KEY_ENTER;
            KC_PAUSE:     key_kind = KEY_PAUSE;
            KC_TOGGLE:    key_kind = KEY_TOGGLE;
            KC_IDLE,
            KC_C,
            KC_D:         key_kind = KEY_NONE; // C and D have no function yet
            default:      key_kind = KEY_NONE; // partial or multi-key codes
        endcase
    end

endmodule

// ==== rtl/input_fsm.sv ====
`timescale 1ns/1ns

module input_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  keypad_pkg::key_kind_t     key_kind,
    input  keypad_pkg::digit_t        key_digit,
    input  logic                      input_enable,  // data memory wants a value
    input  logic                      ignore_input,  // uart transfer in progress
    input  logic                      digits_full,
    input  logic                      digits_empty,
    input  logic                      value_nonzero,
    output input_ctrl_pkg::accum_op_t accum_op,
    output keypad_pkg::digit_t        push_digit,
    output input_ctrl_pkg::count_op_t count_op,
    output logic                      input_complete,
    output logic                      switch_enable,
    output logic                      cpu_pause
);
    import keypad_pkg::*;
    import input_ctrl_pkg::*;

    input_state_t state;
    input_state_t state_next;
    logic         complete_next;
    logic         switch_next;
    logic         pause_next;
    logic         leading_zero;

    assign push_digit   = key_digit;
    assign leading_zero = (key_digit == 4'd0) && !value_nonzero; // not a significant digit

    always_comb begin
        state_next    = state;
        complete_next = input_complete;
        switch_next   = switch_enable;
        pause_next    = cpu_pause;
        accum_op      = ACC_HOLD;
        count_op      = CNT_HOLD;
        case (state)
            ST_BLOCK: begin
                if (key_kind == KEY_PAUSE) begin // pause wins, even during uart
                    state_next = ST_HALT;
                    pause_next = 1'b1;
                end else if (input_enable) begin
                    state_next    = ST_KEYPAD;
                    complete_next = 1'b0;
                    accum_op      = ACC_CLEAR; // fresh number per request
                end
            end
            ST_SWITCH: begin
                case (key_kind)
                    KEY_TOGGLE: begin
                        state_next  = ST_KEYPAD;
                        switch_next = 1'b0;
                    end
                    KEY_ENTER: begin
                        state_next    = ST_BLOCK;
                        complete_next = 1'b1;
                        count_op      = CNT_CLEAR;
                    end
                    KEY_PAUSE: begin
                        state_next    = ST_HALT;
                        pause_next    = 1'b1;
                        complete_next = 1'b1;
                        count_op      = CNT_CLEAR;
                    end
                    default: ;
                endcase
            end
            ST_KEYPAD: begin
                if (!input_enable) begin
                    state_next = ST_BLOCK; // request withdrawn
                end else begin
                    case (key_kind)
                        KEY_TOGGLE: begin
                            state_next  = ST_SWITCH;
                            switch_next = 1'b1;
                        end
                        KEY_BACKSPACE: begin
                            if (!digits_empty) begin
                                accum_op = ACC_POP;
                                count_op = CNT_DEC;
                            end
                        end
                        KEY_ENTER: begin
                            state_next    = ST_BLOCK;
                            complete_next = 1'b1;
                            count_op      = CNT_CLEAR;
                        end
                        KEY_PAUSE: begin
                            state_next    = ST_HALT;
                            pause_next    = 1'b1;
                            complete_next = 1'b1;
                            count_op      = CNT_CLEAR;
                        end
                        KEY_DIGIT: begin
                            if (!digits_full) begin // extra digits are dropped
                                accum_op = ACC_PUSH;
                                if (!leading_zero) count_op = CNT_INC;
                            end
                        end
                        default: ;
                    endcase
                end
            end
            ST_HALT: begin
                if (key_kind == KEY_PAUSE && !ignore_input) begin // resume
                    state_next = ST_BLOCK;
                    pause_next = 1'b0;
                end
            end
            default: state_next = ST_BLOCK;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ST_BLOCK;
            input_complete <= 1'b0;
            switch_enable  <= 1'b0;
            cpu_pause      <= 1'b0;
        end else begin
            state          <= state_next;
            input_complete <= complete_next;
            switch_enable  <= switch_next;
            cpu_pause      <= pause_next;
        end
    end

    // the hazard unit relies on pause and the halt state moving together
    a_pause_in_halt: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_pause |-> (state == ST_HALT))
        else $error("cpu_pause high outside halt state");

endmodule

// ==== rtl/digit_counter.sv ====
`timescale 1ns/1ns
`include "input_consts.svh"

module digit_counter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  input_ctrl_pkg::count_op_t count_op,
    output logic                      digits_full,
    output logic                      digits_empty,
    output logic                      overflow_9th,  // led, ninth tube in use
    output logic                      overflow_10th  // led, all tubes in use
);
    import input_ctrl_pkg::*;

    localparam logic [3:0] LIMIT = 4'(`MAX_DIGITS);

    logic [3:0] count; // significant digits only

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= 4'd0;
        end else begin
            case (count_op)
                CNT_CLEAR: count <= 4'd0;
                CNT_INC:   count <= count + 4'd1;
                CNT_DEC:   count <= count - 4'd1;
                default:   count <= count;
            endcase
        end
    end

    assign digits_full   = (count == LIMIT);
    assign digits_empty  = (count == 4'd0);
    assign overflow_9th  = (count >= LIMIT - 4'd1);
    assign overflow_10th = (count == LIMIT);

    // the controller must stop incrementing once the display is full
    a_count_limit: assert property (@(posedge clk) disable iff (!rst_n)
        count <= LIMIT)
        else $error("digit count above limit");

endmodule

// ==== rtl/decimal_accum.sv ====
`timescale 1ns/1ns
`include "input_consts.svh"

module decimal_accum (
    input  logic                      clk,
    input  logic                      rst_n,
    input  input_ctrl_pkg::accum_op_t accum_op,
    input  keypad_pkg::digit_t        push_digit,
    output logic [`ISA_WIDTH-1:0]     value,
    output logic                      value_nonzero
);
    import keypad_pkg::*;
    import input_ctrl_pkg::*;

    localparam int W = `ISA_WIDTH;

    logic [W-1:0] shifted; // value * 10 + digit, wraps at the word width
    logic [W-1:0] dropped; // value with its last digit removed

    assign shifted = value * W'(10) + W'(push_digit);
    assign dropped = value / W'(10);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value <= '0;
        end else begin
            case (accum_op)
                ACC_CLEAR: value <= '0;
                ACC_PUSH:  value <= shifted;
                ACC_POP:   value <= dropped;
                default:   value <= value;
            endcase
        end
    end

    assign value_nonzero = |value; // lets the fsm skip leading zeros

    // key_decode only ever hands decimal digits to the fsm
    a_digit_range: assert property (@(posedge clk) disable iff (!rst_n)
        (accum_op == ACC_PUSH) |-> (push_digit <= 4'd9))
        else $error("non-decimal digit pushed: %0d", push_digit);

endmodule

// ==== rtl/input_unit.sv ====
`timescale 1ns/1ns
`include "input_consts.svh"

module input_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  keypad_pkg::key_code_t  key_coord,      // one-cycle pulse per press
    input  logic [`SWITCH_CNT-1:0] switch_map,
    input  logic                   ignore_input,   // from hazard unit during uart
    input  logic                   input_enable,   // from data memory
    output logic                   input_complete, // enter was pressed
    output logic                   switch_enable,  // switches drive the data
    output logic                   cpu_pause,
    output logic                   overflow_9th,
    output logic                   overflow_10th,
    output logic [`ISA_WIDTH-1:0]  input_data
);
    import keypad_pkg::*;
    import input_ctrl_pkg::*;

    key_kind_t             key_kind;
    digit_t                key_digit;
    digit_t                push_digit;
    accum_op_t             accum_op;
    count_op_t             count_op;
    logic                  digits_full;
    logic                  digits_empty;
    logic                  value_nonzero;
    logic [`ISA_WIDTH-1:0] accum_value;

    key_decode u_key_decode (
        .key_coord (key_coord),
        .key_kind  (key_kind),
        .key_digit (key_digit)
    );

    input_fsm u_input_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_kind       (key_kind),
        .key_digit      (key_digit),
        .input_enable   (input_enable),
        .ignore_input   (ignore_input),
        .digits_full    (digits_full),
        .digits_empty   (digits_empty),
        .value_nonzero  (value_nonzero),
        .accum_op       (accum_op),
        .push_digit     (push_digit),
        .count_op       (count_op),
        .input_complete (input_complete),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause)
    );

    digit_counter u_digit_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .count_op      (count_op),
        .digits_full   (digits_full),
        .digits_empty  (digits_empty),
        .overflow_9th  (overflow_9th),
        .overflow_10th (overflow_10th)
    );

    decimal_accum u_decimal_accum (
        .clk           (clk),
        .rst_n         (rst_n),
        .accum_op      (accum_op),
        .push_digit    (push_digit),
        .value         (accum_value),
        .value_nonzero (value_nonzero)
    );

    // switches are zero-extended to the data word
    assign input_data = switch_enable ?
        {{(`ISA_WIDTH - `SWITCH_CNT){1'b0}}, switch_map} : accum_value;

endmodule

// ==== test/input_unit_tb.sv ====
`timescale 1ns/1ns
`include "input_consts.svh"

module input_unit_tb;
    import keypad_pkg::*;

    localparam int MAX_LINES   = 500; // bound on case file length
    localparam int RESET_LIMIT = 50;
    localparam int OPEN_TRIES  = 3;

    logic                   clk = 1'b0;
    logic                   rst_n;
    key_code_t              key_coord;
    logic [`SWITCH_CNT-1:0] switch_map;
    logic                   input_enable;
    logic                   ignore_input;
    logic                   input_complete;
    logic                   switch_enable;
    logic                   cpu_pause;
    logic                   overflow_9th;
    logic                   overflow_10th;
    logic [`ISA_WIDTH-1:0]  input_data;

    int fd;
    int error_count;
    int test_errors;
    int test_steps;
    int tests_run;
    int tests_failed;
    int step_count;
    int cur_test;
    bit aborted;

    input_unit uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_coord      (key_coord),
        .switch_map     (switch_map),
        .ignore_input   (ignore_input),
        .input_enable   (input_enable),
        .input_complete (input_complete),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause),
        .overflow_9th   (overflow_9th),
        .overflow_10th  (overflow_10th),
        .input_data     (input_data)
    );

    always #10 clk = ~clk; // 20 ns period

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] test %0d step %0d %s expected %h got %h",
                     cur_test, step_count, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic report_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d: ok, %0d steps", cur_test, test_steps);
        end else begin
            $display("test %0d: %0d mismatches in %0d steps", cur_test, test_errors, test_steps);
            tests_failed++;
        end
    endtask

    // press lasts one cycle, outputs are settled by the following falling edge
    task automatic apply_step(input logic [31:0] key, input logic [31:0] sw,
                              input logic [31:0] en, input logic [31:0] ign);
        @(posedge clk);
        key_coord    <= key[7:0];
        switch_map   <= sw[`SWITCH_CNT-1:0];
        input_enable <= en[0];
        ignore_input <= ign[0];
        @(posedge clk);
        key_coord <= KC_IDLE;
        @(negedge clk);
    endtask

    initial begin : main
        string       line;
        int          fields;
        int          test_no;
        int          wait_cycles;
        int          tries;
        int          line_count;
        logic [31:0] f_key;
        logic [31:0] f_sw;
        logic [31:0] f_en;
        logic [31:0] f_ign;
        logic [31:0] e_data;
        logic [31:0] e_comp;
        logic [31:0] e_swe;
        logic [31:0] e_pause;
        logic [31:0] e_ov9;
        logic [31:0] e_ov10;

        key_coord    = KC_IDLE;
        switch_map   = '0;
        input_enable = 1'b0;
        ignore_input = 1'b0;
        error_count  = 0;
        test_errors  = 0;
        test_steps   = 0;
        tests_run    = 0;
        tests_failed = 0;
        step_count   = 0;
        line_count   = 0;
        cur_test     = -1;
        aborted      = 1'b0;
        fd           = 0;

        wait_cycles = 0;
        while (rst_n !== 1'b1 && wait_cycles < RESET_LIMIT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            aborted = 1'b1;
        end

        tries = 0;
        while (!aborted && fd == 0 && tries < OPEN_TRIES) begin
            fd = $fopen("test/input_cases.txt", "r");
            tries++;
            if (fd == 0) @(posedge clk);
        end
        if (!aborted && fd == 0) begin
            $display("could not open test/input_cases.txt");
            aborted = 1'b1;
        end

        while (!aborted && !$feof(fd) && line_count < MAX_LINES) begin
            line_count++;
            line   = "";
            fields = $fgets(line, fd);
            if (fields == 0 || line.len() < 2 || line.getc(0) == "#") continue;
            fields = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h", test_no, f_key, f_sw,
                             f_en, f_ign, e_data, e_comp, e_swe, e_pause, e_ov9, e_ov10);
            if (fields != 11) begin
                $display("case file line %0d could not be parsed", line_count);
                error_count++;
                continue;
            end
            if (test_no != cur_test) begin
                if (cur_test >= 0) report_test();
                cur_test    = test_no;
                test_errors = 0;
                test_steps  = 0;
            end
            step_count++;
            test_steps++;
            apply_step(f_key, f_sw, f_en, f_ign);
            check_value("input_data", e_data, input_data);
            check_value("input_complete", e_comp, {31'b0, input_complete});
            check_value("switch_enable", e_swe, {31'b0, switch_enable});
            check_value("cpu_pause", e_pause, {31'b0, cpu_pause});
            check_value("overflow_9th", e_ov9, {31'b0, overflow_9th});
            check_value("overflow_10th", e_ov10, {31'b0, overflow_10th});
        end
        if (cur_test >= 0) report_test();
        if (fd != 0) $fclose(fd);
        if (!aborted && step_count == 0) begin
            $display("case file held no steps");
            aborted = 1'b1;
        end

        $display("%0d tests, %0d failed, %0d steps, %0d mismatches",
                 tests_run, tests_failed, step_count, error_count);
        if (!aborted && error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== test/input_cases.txt ====
# test key sw en ign : input_data complete switch_enable cpu_pause overflow_9th overflow_10th
# test number in decimal, all other columns in hex, each step checked one cycle after it
1 00 0000 0 0 00000000 0 0 0 0 0
1 de 0000 0 0 00000000 0 0 0 0 0
1 7b 0000 0 0 00000000 0 0 0 0 0
1 b7 0000 0 0 00000000 0 0 0 0 0
1 e7 0000 0 0 00000000 0 0 1 0 0
1 e7 0000 0 0 00000000 0 0 0 0 0
2 00 0000 1 0 00000000 0 0 0 0 0
2 de 0000 1 0 00000004 0 0 0 0 0
2 7d 0000 1 0 00000028 0 0 0 0 0
2 be 0000 1 0 00000197 0 0 0 0 0
2 7b 0000 1 0 00000197 1 0 0 0 0
3 7d 0000 1 0 00000000 0 0 0 0 0
3 7e 0000 1 0 00000000 0 0 0 0 0
3 dd 0000 1 0 00000005 0 0 0 0 0
3 ed 0000 1 0 00000034 0 0 0 0 0
3 bd 0000 1 0 00000210 0 0 0 0 0
3 7e 0000 1 0 00000034 0 0 0 0 0
3 7e 0000 1 0 00000005 0 0 0 0 0
3 7e 0000 1 0 00000000 0 0 0 0 0
3 7e 0000 1 0 00000000 0 0 0 0 0
4 bb 0000 1 0 00000009 0 0 0 0 0
4 bd 0000 1 0 00000062 0 0 0 0 0
4 be 0000 1 0 000003db 0 0 0 0 0
4 db 0000 1 0 00002694 0 0 0 0 0
4 dd 0000 1 0 000181cd 0 0 0 0 0
4 de 0000 1 0 000f1206 0 0 0 0 0
4 eb 0000 1 0 0096b43f 0 0 0 0 0
4 ed 0000 1 0 05e30a78 0 0 0 0 0
4 ee 0000 1 0 3ade68b1 0 0 0 1 0
4 bb 0000 1 0 4cb016f3 0 0 0 1 1
4 dd 0000 1 0 4cb016f3 0 0 0 1 1
4 7e 0000 1 0 07ab357e 0 0 0 1 0
5 d7 a5c3 1 0 0000a5c3 0 1 0 1 0
5 dd 1234 1 0 00001234 0 1 0 1 0
5 d7 1234 1 0 07ab357e 0 0 0 1 0
5 7b 1234 1 0 07ab357e 1 0 0 0 0
6 eb 0000 1 0 00000003 0 0 0 0 0
6 e7 0000 1 0 00000003 1 0 1 0 0
6 e7 0000 1 1 00000003 1 0 1 0 0
6 e7 0000 1 0 00000003 1 0 0 0 0
6 00 0000 0 0 00000000 0 0 0 0 0
6 e7 0000 0 1 00000000 0 0 1 0 0
6 e7 0000 0 0 00000000 0 0 0 0 0

// ==== filelist.f ====
+incdir+rtl
rtl/keypad_pkg.sv
rtl/input_ctrl_pkg.sv
rtl/key_decode.sv
rtl/input_fsm.sv
rtl/digit_counter.sv
rtl/decimal_accum.sv
rtl/input_unit.sv
test/input_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= input_unit_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

SIM_BIN := $(BUILD_DIR)/$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)
